//--- cache_pkg.sv
package cache_pkg;

    // geometry of the direct-mapped instruction cache
    localparam int addr_width     = 32;
    localparam int data_width     = 32;
    localparam int num_lines      = 16;
    localparam int line_bytes     = 16;

    localparam int offset_width   = $clog2(line_bytes);
    localparam int index_width    = $clog2(num_lines);
    localparam int tag_width      = addr_width - index_width - offset_width;
    localparam int line_width     = line_bytes * 8;

    localparam int words_per_line = line_bytes / (data_width / 8);
    localparam int word_sel_width = $clog2(words_per_line);
    localparam int byte_sel_width = offset_width - word_sel_width;

    // controller state codes
    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_compare = 2'd1;
    localparam logic [1:0] st_refill  = 2'd2;

    // fetch address seen either as one word or split into its cache fields
    typedef union packed {
        logic [addr_width-1:0] raw;
        struct packed {
            logic [tag_width-1:0]      tag;
            logic [index_width-1:0]    index;
            logic [word_sel_width-1:0] word_sel;  // word within the line
            logic [byte_sel_width-1:0] byte_sel;  // always zero for fetches
        } f;
    } fetch_addr_u;

endpackage

//--- bus_pkg.sv
package bus_pkg;

    localparam int apb_addr_width = 32;
    localparam int apb_data_width = 32;

    // one cache line is fetched as this many read beats
    localparam int beats_per_line = 4;
    localparam int beat_width     = $clog2(beats_per_line);
    localparam int word_shift     = $clog2(apb_data_width / 8);  // byte address step per beat

    localparam logic [beat_width-1:0] last_beat = beat_width'(beats_per_line - 1);

    // refill engine state codes
    localparam logic [1:0] rf_idle   = 2'd0;
    localparam logic [1:0] rf_setup  = 2'd1;
    localparam logic [1:0] rf_access = 2'd2;

endpackage

//--- icache.sv
module icache (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [cache_pkg::addr_width-1:0] cpu_addr,
    input  logic                             cpu_req,
    input  logic                             flush,
    output logic [cache_pkg::data_width-1:0] cpu_data,
    output logic                             cpu_hit,
    output logic                             cpu_ready,
    output logic                             line_req,
    output logic [cache_pkg::addr_width-1:0] line_addr,
    input  logic [cache_pkg::line_width-1:0] line_data,
    input  logic                             line_valid
);

    logic [1:0] state;
    logic [1:0] state_nxt;

    cache_pkg::fetch_addr_u req_addr;  // address of the fetch in flight

    logic [cache_pkg::tag_width-1:0]  tag_array  [cache_pkg::num_lines];
    logic [cache_pkg::line_width-1:0] data_array [cache_pkg::num_lines];
    logic [cache_pkg::num_lines-1:0]  valid;

    logic                             tag_match;
    logic                             fill_done;
    logic [cache_pkg::line_width-1:0] hit_line;
    logic [cache_pkg::data_width-1:0] hit_word;
    logic [cache_pkg::data_width-1:0] fill_word;

    // lookup on the latched address
    assign hit_line  = data_array[req_addr.f.index];
    assign tag_match = valid[req_addr.f.index]
                       && (tag_array[req_addr.f.index] == req_addr.f.tag);
    assign cpu_hit   = (state == cache_pkg::st_compare) && tag_match;

    assign hit_word  = hit_line[req_addr.f.word_sel * cache_pkg::data_width +:
                                cache_pkg::data_width];
    assign fill_word = line_data[req_addr.f.word_sel * cache_pkg::data_width +:
                                 cache_pkg::data_width];

    assign fill_done = (state == cache_pkg::st_refill) && line_valid;

    // refill always works on whole lines
    assign line_addr = {req_addr.f.tag, req_addr.f.index, {cache_pkg::offset_width{1'b0}}};

    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::st_idle: begin
                if (cpu_req) begin
                    state_nxt = cache_pkg::st_compare;
                end
            end
            cache_pkg::st_compare: begin
                state_nxt = tag_match ? cache_pkg::st_idle : cache_pkg::st_refill;
            end
            cache_pkg::st_refill: begin
                if (line_valid) begin
                    state_nxt = cache_pkg::st_idle;
                end
            end
            default: state_nxt = cache_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= cache_pkg::st_idle;
            cpu_ready <= 1'b0;
            line_req  <= 1'b0;
        end else begin
            state     <= state_nxt;
            cpu_ready <= cpu_hit || fill_done;  // one cycle after compare or fill
            line_req  <= ((state == cache_pkg::st_compare) && !tag_match)
                         || ((state == cache_pkg::st_refill) && !line_valid);
        end
    end

    // request address and returned word
    always_ff @(posedge clk) begin
        if ((state == cache_pkg::st_idle) && cpu_req) begin
            req_addr.raw <= cpu_addr;
        end
        if (cpu_hit) begin
            cpu_data <= hit_word;
        end else if (fill_done) begin
            cpu_data <= fill_word;  // forward straight from the incoming line
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_array[req_addr.f.index]  <= req_addr.f.tag;
            data_array[req_addr.f.index] <= line_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if ((state == cache_pkg::st_idle) && flush) begin
            valid <= '0;  // fence.i
        end else if (fill_done) begin
            valid[req_addr.f.index] <= 1'b1;
        end
    end

endmodule

//--- icache_refill.sv
module icache_refill (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               line_req,
    input  logic [bus_pkg::apb_addr_width-1:0] line_addr,
    output logic [cache_pkg::line_width-1:0]   line_data,
    output logic                               line_valid,
    output logic                               psel,
    output logic                               penable,
    output logic [bus_pkg::apb_addr_width-1:0] paddr,
    input  logic [bus_pkg::apb_data_width-1:0] prdata,
    input  logic                               pready
);

    logic [1:0]                        state;
    logic [bus_pkg::beat_width-1:0]    beat;
    logic                              wait_drop;  // line delivered, request not yet gone
    logic                              beat_done;
    logic [bus_pkg::apb_addr_width-1:0] beat_offset;
    logic [cache_pkg::line_width-1:0]  line_buf;

    assign beat_done = (state == bus_pkg::rf_access) && pready;

    assign beat_offset = {{(bus_pkg::apb_addr_width - bus_pkg::beat_width
                            - bus_pkg::word_shift){1'b0}},
                          beat, {bus_pkg::word_shift{1'b0}}};

    assign psel      = (state != bus_pkg::rf_idle);
    assign penable   = (state == bus_pkg::rf_access);
    assign paddr     = line_addr + beat_offset;
    assign line_data = line_buf;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= bus_pkg::rf_idle;
            beat       <= '0;
            line_valid <= 1'b0;
            wait_drop  <= 1'b0;
        end else begin
            line_valid <= 1'b0;
            if (!line_req) begin
                wait_drop <= 1'b0;
            end
            case (state)
                bus_pkg::rf_idle: begin
                    if (line_req && !wait_drop) begin
                        state <= bus_pkg::rf_setup;
                        beat  <= '0;
                    end
                end
                bus_pkg::rf_setup: begin
                    state <= bus_pkg::rf_access;
                end
                bus_pkg::rf_access: begin
                    if (pready) begin  // slave may stretch the access phase
                        if (beat == bus_pkg::last_beat) begin
                            state      <= bus_pkg::rf_idle;
                            line_valid <= 1'b1;
                            wait_drop  <= 1'b1;
                        end else begin
                            state <= bus_pkg::rf_setup;
                            beat  <= beat + 1'b1;
                        end
                    end
                end
                default: state <= bus_pkg::rf_idle;
            endcase
        end
    end

    // each beat lands at its own word position in the line
    always_ff @(posedge clk) begin
        if (beat_done) begin
            line_buf[beat * bus_pkg::apb_data_width +: bus_pkg::apb_data_width] <= prdata;
        end
    end

endmodule

//--- icache_top.sv
module icache_top (
    input  logic                               clk,
    input  logic                               rst,

    input  logic [cache_pkg::addr_width-1:0]   cpu_addr,
    input  logic                               cpu_req,
    input  logic                               flush,
    output logic [cache_pkg::data_width-1:0]   cpu_data,
    output logic                               cpu_hit,
    output logic                               cpu_ready,

    output logic                               psel,
    output logic                               penable,
    output logic [bus_pkg::apb_addr_width-1:0] paddr,
    input  logic [bus_pkg::apb_data_width-1:0] prdata,
    input  logic                               pready
);

    // refill handshake
    logic                             line_req;
    logic [cache_pkg::addr_width-1:0] line_addr;
    logic [cache_pkg::line_width-1:0] line_data;
    logic                             line_valid;

    icache u_icache (
        .clk        (clk),
        .rst        (rst),
        .cpu_addr   (cpu_addr),
        .cpu_req    (cpu_req),
        .flush      (flush),
        .cpu_data   (cpu_data),
        .cpu_hit    (cpu_hit),
        .cpu_ready  (cpu_ready),
        .line_req   (line_req),
        .line_addr  (line_addr),
        .line_data  (line_data),
        .line_valid (line_valid)
    );

    icache_refill u_icache_refill (
        .clk        (clk),
        .rst        (rst),
        .line_req   (line_req),
        .line_addr  (line_addr),
        .line_data  (line_data),
        .line_valid (line_valid),
        .psel       (psel),
        .penable    (penable),
        .paddr      (paddr),
        .prdata     (prdata),
        .pready     (pready)
    );

endmodule

//--- tb_apb_mem.sv
module tb_apb_mem (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               psel,
    input  logic                               penable,
    input  logic [bus_pkg::apb_addr_width-1:0] paddr,
    output logic [bus_pkg::apb_data_width-1:0] prdata,
    output logic                               pready
);
    timeunit 1ns;
    timeprecision 1ps;

    // every word holds its own address scrambled with this pattern
    localparam logic [bus_pkg::apb_data_width-1:0] fill_pattern = 32'h1357_9BDF;

    logic [1:0] wait_left;  // access cycles still to stretch

    // a fresh wait count is drawn in each setup phase
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_left <= 2'd0;
        end else if (psel && !penable) begin
            wait_left <= 2'($urandom_range(3, 0));
        end else if (penable && (wait_left != 2'd0)) begin
            wait_left <= wait_left - 2'd1;
        end
    end

    assign pready = psel && penable && (wait_left == 2'd0);
    assign prdata = pready ? (paddr ^ fill_pattern) : '0;

endmodule

//--- icache_sva.sv
module icache_sva (
    input logic                               clk,
    input logic                               rst,
    input logic                               cpu_ready,
    input logic                               psel,
    input logic                               penable,
    input logic                               pready,
    input logic [bus_pkg::apb_addr_width-1:0] paddr,
    input logic                               line_req,
    input logic                               line_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // every beat opens with a setup cycle
    setup_before_access: assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> $past(psel))
        else $error("penable rose without a setup cycle");

    paddr_held: assert property (@(posedge clk) disable iff (rst)
        (penable && !pready) |=> $stable(paddr))  // slave is stretching the beat
        else $error("paddr changed during a stretched access phase");

    ready_is_pulse: assert property (@(posedge clk) disable iff (rst)
        cpu_ready |=> !cpu_ready)
        else $error("cpu_ready held for more than one cycle");

    fill_only_on_request: assert property (@(posedge clk) disable iff (rst)
        line_valid |-> line_req)
        else $error("line_valid without an open line_req");

endmodule

//--- tb_icache_top.sv
module tb_icache_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [cache_pkg::data_width-1:0] mem_pattern = 32'h1357_9BDF;
    localparam logic [cache_pkg::addr_width-1:0] line_base   = 32'h0000_1000;
    localparam logic [cache_pkg::addr_width-1:0] rand_base   = 32'h0000_4000;
    localparam logic [cache_pkg::addr_width-1:0] rand_mask   = 32'h0000_30FC;  // 4 tags, all lines

    logic                               clk = 1'b0;
    logic                               rst;
    logic [cache_pkg::addr_width-1:0]   cpu_addr;
    logic                               cpu_req;
    logic                               flush;
    logic [cache_pkg::data_width-1:0]   cpu_data;
    logic                               cpu_hit;
    logic                               cpu_ready;
    logic                               psel;
    logic                               penable;
    logic [bus_pkg::apb_addr_width-1:0] paddr;
    logic [bus_pkg::apb_data_width-1:0] prdata;
    logic                               pready;

    // shadow copy of the tag store
    logic                            shadow_valid [cache_pkg::num_lines];
    logic [cache_pkg::tag_width-1:0] shadow_tag   [cache_pkg::num_lines];

    logic [cache_pkg::data_width-1:0] exp_word;
    logic                             exp_hit;
    logic                             hit_sample;
    logic                             req_q = 1'b0;
    event                             compare_done;

    int issued        = 0;
    int answered      = 0;
    int cycle_count   = 0;
    int pass_count    = 0;
    int error_count   = 0;
    int test_requests = 0;
    int test_mark     = 0;

    always #5 clk = ~clk;

    icache_top u_icache_top (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .cpu_req   (cpu_req),
        .flush     (flush),
        .cpu_data  (cpu_data),
        .cpu_hit   (cpu_hit),
        .cpu_ready (cpu_ready),
        .psel      (psel),
        .penable   (penable),
        .paddr     (paddr),
        .prdata    (prdata),
        .pready    (pready)
    );

    tb_apb_mem u_apb_mem (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .paddr   (paddr),
        .prdata  (prdata),
        .pready  (pready)
    );

    bind icache_top icache_sva u_icache_sva (
        .clk        (clk),
        .rst        (rst),
        .cpu_ready  (cpu_ready),
        .psel       (psel),
        .penable    (penable),
        .pready     (pready),
        .paddr      (paddr),
        .line_req   (line_req),
        .line_valid (line_valid)
    );

    function automatic logic [cache_pkg::data_width-1:0] expected_word(
        input logic [cache_pkg::addr_width-1:0] addr);
        return addr ^ mem_pattern;
    endfunction

    task automatic check_word(input logic [cache_pkg::data_width-1:0] got,
                              input logic [cache_pkg::data_width-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED cpu_data addr %h: got %h, expected %h", cpu_addr, got, exp);
            error_count = error_count + 1;
        end else begin
            pass_count = pass_count + 1;
        end
    endtask

    task automatic check_hit(input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED cpu_hit addr %h: got %h, expected %h", cpu_addr, got, exp);
            error_count = error_count + 1;
        end else begin
            pass_count = pass_count + 1;
        end
    endtask

    // one fetch: predict, request, wait for the compare process
    task automatic fetch(input logic [cache_pkg::addr_width-1:0] addr);
        cache_pkg::fetch_addr_u fa;
        fa.raw   = addr;
        exp_word = expected_word(addr);
        exp_hit  = shadow_valid[fa.f.index] && (shadow_tag[fa.f.index] == fa.f.tag);
        shadow_valid[fa.f.index] = 1'b1;
        shadow_tag[fa.f.index]   = fa.f.tag;
        cpu_addr = addr;
        cpu_req  = 1'b1;
        issued   = issued + 1;
        test_requests = test_requests + 1;
        @(posedge clk);
        #1 cpu_req = 1'b0;
        @(compare_done);
        @(posedge clk);
        #1;
    endtask

    task automatic flush_cache();
        flush = 1'b1;
        @(posedge clk);
        #1 flush = 1'b0;
        for (int i = 0; i < cache_pkg::num_lines; i++) begin
            shadow_valid[i] = 1'b0;
        end
    endtask

    task automatic start_test();
        test_mark     = error_count;
        test_requests = 0;
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d fetches, %0d errors", num, name, test_requests,
                 error_count - test_mark);
    endtask

    always @(posedge clk) begin
        req_q <= cpu_req;  // high during the compare cycle
    end

    // compare process, sampled away from the rising edge
    always @(negedge clk) begin
        if (req_q) begin
            hit_sample = cpu_hit;
        end
        if (cpu_ready) begin
            if (answered >= issued) begin
                $display("cpu_ready pulsed with no fetch outstanding");
                error_count = error_count + 1;
            end else begin
                check_word(cpu_data, exp_word);
                check_hit(hit_sample, exp_hit);
                answered = answered + 1;
                -> compare_done;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > 200 * issued + 100) begin
            $display("timeout: no response after %0d cycles, %0d fetches issued",
                     cycle_count, issued);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(21755));
        rst      = 1'b1;
        cpu_addr = '0;
        cpu_req  = 1'b0;
        flush    = 1'b0;
        for (int i = 0; i < cache_pkg::num_lines; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i]   = '0;
        end
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        #1;

        start_test();
        for (int i = 0; i < cache_pkg::num_lines; i++) begin
            fetch(line_base + i * cache_pkg::line_bytes + (i % 4) * 4);
        end
        report_test(1, "cold miss");

        start_test();
        for (int i = 0; i < cache_pkg::num_lines; i++) begin
            for (int w = 0; w < 4; w++) begin
                fetch(line_base + i * cache_pkg::line_bytes + w * 4);
            end
        end
        report_test(2, "refetch hits");

        // same index 4, tags 0x000020 and 0x000820
        start_test();
        for (int k = 0; k < 8; k++) begin
            fetch((k % 2 == 0) ? 32'h0000_2040 : 32'h0008_2048);
        end
        report_test(3, "conflict eviction");

        start_test();
        flush_cache();
        for (int i = 0; i < cache_pkg::num_lines; i++) begin
            fetch(line_base + i * cache_pkg::line_bytes + 8);
        end
        report_test(4, "flush");

        start_test();
        for (int n = 0; n < 300; n++) begin
            fetch(rand_base + ($urandom & rand_mask));
        end
        report_test(5, "random mix");

        $display("checks passed %0d, errors %0d", pass_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- flist.f
cache_pkg.sv
bus_pkg.sv
icache.sv
icache_refill.sv
icache_top.sv
tb_apb_mem.sv
icache_sva.sv
tb_icache_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_icache_top -f flist.f -o sim_icache_top \
    && ./obj_dir/sim_icache_top > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qs "^Test completed successfully$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }
